//--- pbus_config.svh
`ifndef PBUS_CONFIG_SVH
`define PBUS_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////////////////////////

`define PBUS_DATA_WIDTH   32          // always 32 bit, one clock
`define PBUS_ADDR_WIDTH   32
`define PBUS_BASE         16'h2000    // upper half of every bus address

//////////////////////////////////////////////////////////////////////
// peripherals and interrupts
//////////////////////////////////////////////////////////////////////

`define PBUS_NUM_GPIO_IN  8           // input pins
`define PBUS_NUM_GPIO_OUT 8           // output pins

`define PBUS_NUM_IRQ      3           // width of int_o
`define PBUS_IRQ_GPIO     0           // input change
`define PBUS_IRQ_TIM0     1
`define PBUS_IRQ_TIM1     2

`endif

//--- pbus_map_pkg.sv
`include "pbus_config.svh"

package pbus_map_pkg;

    // slots inside the bus window
    typedef enum logic [3:0] {
        SLOT_GPIO = 4'd0,               // gpio in/out
        SLOT_TIM0 = 4'd1,               // first timer
        SLOT_TIM1 = 4'd2                // second timer
    } pbus_slot_e;                      // other codes are unmapped

    typedef logic [3:0] pbus_reg_idx_t; // word index inside one slot

    // field view of a bus address
    typedef struct packed {
        logic [15:0]   base;            // must equal PBUS_BASE
        logic [3:0]    slot;            // raw code, may be unmapped
        logic [5:0]    reserved;
        pbus_reg_idx_t reg_idx;
        logic [1:0]    byte_off;        // full words only
    } pbus_addr_fields_t;

    // one address word, raw on the bus and split in the decoder
    typedef union packed {
        logic [`PBUS_ADDR_WIDTH-1:0] raw;
        pbus_addr_fields_t           f;
    } pbus_addr_u;

endpackage : pbus_map_pkg

//--- pbus_reg_pkg.sv
package pbus_reg_pkg;

    // gpio register map
    typedef enum logic [3:0] {
        GPIO_OUT      = 4'd0,           // output latch
        GPIO_IN       = 4'd1,           // synchronized pins, read only
        GPIO_IRQ_EN   = 4'd2,
        GPIO_IRQ_PEND = 4'd3            // w1c on bit 0
    } gpio_reg_e;

    // timer register map
    typedef enum logic [3:0] {
        TIM_LOAD   = 4'd0,              // also preloads the counter
        TIM_COUNT  = 4'd1,              // live value
        TIM_CTRL   = 4'd2,
        TIM_STATUS = 4'd3               // pending bit, w1c
    } tim_reg_e;

    // bit positions in TIM_CTRL
    typedef enum int unsigned {
        CTRL_EN     = 0,
        CTRL_RELOAD = 1,                // periodic instead of one-shot
        CTRL_IRQ_EN = 2
    } tim_ctrl_bit_e;

    // response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11             // nothing mapped here
    } pbus_resp_e;

endpackage : pbus_reg_pkg

//--- pbus_addr_decode.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module pbus_addr_decode (
    input  pbus_map_pkg::pbus_addr_u    awaddr_i,   // write address
    input  pbus_map_pkg::pbus_addr_u    araddr_i,   // read address
    output pbus_map_pkg::pbus_slot_e    wr_slot_o,
    output pbus_map_pkg::pbus_slot_e    rd_slot_o,
    output pbus_map_pkg::pbus_reg_idx_t wr_idx_o,
    output pbus_map_pkg::pbus_reg_idx_t rd_idx_o,
    output logic                        wr_err_o,   // decerr for the write
    output logic                        rd_err_o    // decerr for the read
);

    import pbus_map_pkg::*;

    localparam pbus_slot_e SLOT_NONE = pbus_slot_e'(4'hf);  // selects nobody

    logic wr_base_ok;
    logic rd_base_ok;

    function automatic logic slot_mapped(logic [3:0] slot);
        return slot inside {SLOT_GPIO, SLOT_TIM0, SLOT_TIM1};
    endfunction

    // window check on the upper half
    assign wr_base_ok = (awaddr_i.f.base == `PBUS_BASE);
    assign rd_base_ok = (araddr_i.f.base == `PBUS_BASE);

    // error path
    assign wr_err_o = !wr_base_ok || !slot_mapped(awaddr_i.f.slot);
    assign rd_err_o = !rd_base_ok || !slot_mapped(araddr_i.f.slot);

    // select path, slot code passes only inside the window
    assign wr_slot_o = wr_base_ok ? pbus_slot_e'(awaddr_i.f.slot) : SLOT_NONE;
    assign rd_slot_o = rd_base_ok ? pbus_slot_e'(araddr_i.f.slot) : SLOT_NONE;
    assign wr_idx_o  = wr_err_o ? '0 : awaddr_i.f.reg_idx;
    assign rd_idx_o  = rd_err_o ? '0 : araddr_i.f.reg_idx;

endmodule : pbus_addr_decode

//--- pbus_gpio.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module pbus_gpio (
    input  logic                          pbus_clock_i,
    input  logic                          rst_n_i,
    input  logic                          we_i,         // slot-gated accept strobe
    input  pbus_map_pkg::pbus_reg_idx_t   wr_idx_i,
    input  logic [`PBUS_DATA_WIDTH-1:0]   wdata_i,
    input  pbus_map_pkg::pbus_reg_idx_t   rd_idx_i,
    input  logic [`PBUS_NUM_GPIO_IN-1:0]  gpio_in_i,    // asynchronous pins
    output logic [`PBUS_NUM_GPIO_OUT-1:0] gpio_out_o,
    output logic [`PBUS_DATA_WIDTH-1:0]   rdata_o,      // combinational
    output logic                          irq_o
);

    import pbus_reg_pkg::*;

    logic [`PBUS_NUM_GPIO_OUT-1:0] out_q;
    logic [`PBUS_NUM_GPIO_IN-1:0]  sync_q1;     // metastability stage
    logic [`PBUS_NUM_GPIO_IN-1:0]  sync_q2;     // value seen by GPIO_IN
    logic [`PBUS_NUM_GPIO_IN-1:0]  prev_q;      // last synchronized value
    logic                          en_q;
    logic                          pend_q;
    logic                          changed;

    assign changed = (sync_q2 != prev_q);       // any pin toggled

    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
            en_q    <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
            if (we_i) begin
                case (wr_idx_i)
                    GPIO_OUT:      out_q <= wdata_i[`PBUS_NUM_GPIO_OUT-1:0];
                    GPIO_IRQ_EN:   en_q  <= wdata_i[0];
                    GPIO_IRQ_PEND: pend_q <= pend_q && !wdata_i[0];    // w1c
                    default:       out_q <= out_q;      // GPIO_IN is read only
                endcase
            end
            if (changed) begin
                pend_q <= 1'b1;                         // new change beats a clear
            end
        end
    end

    always_comb begin
        rdata_o = '0;                                   // upper bits read zero
        case (rd_idx_i)
            GPIO_OUT:      rdata_o[`PBUS_NUM_GPIO_OUT-1:0] = out_q;
            GPIO_IN:       rdata_o[`PBUS_NUM_GPIO_IN-1:0]  = sync_q2;
            GPIO_IRQ_EN:   rdata_o[0] = en_q;
            GPIO_IRQ_PEND: rdata_o[0] = pend_q;
            default:       rdata_o    = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign irq_o      = pend_q && en_q;                 // level

endmodule : pbus_gpio

//--- pbus_timer.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module pbus_timer (
    input  logic                        pbus_clock_i,
    input  logic                        rst_n_i,
    input  logic                        we_i,           // slot-gated accept strobe
    input  pbus_map_pkg::pbus_reg_idx_t wr_idx_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] wdata_i,
    input  pbus_map_pkg::pbus_reg_idx_t rd_idx_i,
    output logic [`PBUS_DATA_WIDTH-1:0] rdata_o,        // combinational
    output logic                        irq_o
);

    import pbus_reg_pkg::*;

    logic [`PBUS_DATA_WIDTH-1:0] load_q;
    logic [`PBUS_DATA_WIDTH-1:0] count_q;
    logic                        en_q;
    logic                        reload_q;
    logic                        irq_en_q;
    logic                        pend_q;
    logic                        wr_load;
    logic                        wr_ctrl;
    logic                        wr_clr;
    logic                        expire;

    assign wr_load = we_i && (wr_idx_i == TIM_LOAD);
    assign wr_ctrl = we_i && (wr_idx_i == TIM_CTRL);
    assign wr_clr  = we_i && (wr_idx_i == TIM_STATUS) && wdata_i[0];
    assign expire  = en_q && (count_q == '0);           // zero reached while running

    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            load_q   <= '0;
            count_q  <= '0;
            en_q     <= 1'b0;
            reload_q <= 1'b0;
            irq_en_q <= 1'b0;
            pend_q   <= 1'b0;
        end else begin
            if (wr_load) begin
                load_q  <= wdata_i;
                count_q <= wdata_i;                     // preload
            end else if (expire && reload_q) begin
                count_q <= load_q;                      // periodic restart
            end else if (en_q && !expire) begin
                count_q <= count_q - 1'b1;
            end
            if (wr_ctrl) begin
                en_q     <= wdata_i[CTRL_EN];
                reload_q <= wdata_i[CTRL_RELOAD];
                irq_en_q <= wdata_i[CTRL_IRQ_EN];
            end else if (expire && !reload_q) begin
                en_q <= 1'b0;                           // one-shot stops at zero
            end
            if (expire) begin
                pend_q <= 1'b1;
            end else if (wr_clr) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (rd_idx_i)
            TIM_LOAD:   rdata_o = load_q;
            TIM_COUNT:  rdata_o = count_q;
            TIM_CTRL: begin
                rdata_o[CTRL_EN]     = en_q;
                rdata_o[CTRL_RELOAD] = reload_q;
                rdata_o[CTRL_IRQ_EN] = irq_en_q;
            end
            TIM_STATUS: rdata_o[0] = pend_q;
            default:    rdata_o    = '0;
        endcase
    end

    assign irq_o = pend_q && irq_en_q;

    // a stopped timer keeps its count unless software reloads it
    a_no_count_when_off: assert property (@(posedge pbus_clock_i) disable iff (!rst_n_i)
        !en_q && !wr_load |=> $stable(count_q));

endmodule : pbus_timer

//--- pbus_resp_mux.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module pbus_resp_mux (
    input  logic                        pbus_clock_i,
    input  logic                        rst_n_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output logic [`PBUS_DATA_WIDTH-1:0] rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    input  logic                        wr_err_i,       // from decode
    input  logic                        rd_err_i,
    input  pbus_map_pkg::pbus_slot_e    rd_slot_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] gpio_rdata_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] tim0_rdata_i,
    input  logic [`PBUS_DATA_WIDTH-1:0] tim1_rdata_i,
    output logic                        we_o            // write accept pulse
);

    import pbus_map_pkg::*;
    import pbus_reg_pkg::*;

    logic                        wr_acc;
    logic                        rd_acc;
    logic [`PBUS_DATA_WIDTH-1:0] slot_rdata;

    // one outstanding response per channel
    assign awready_o = !bvalid_o;
    assign wready_o  = !bvalid_o;                       // aw and w taken together
    assign arready_o = !rvalid_o;
    assign wr_acc    = awvalid_i && wvalid_i && !bvalid_o;
    assign rd_acc    = arvalid_i && !rvalid_o;
    assign we_o      = wr_acc;                          // slot gating at top

    always_comb begin
        case (rd_slot_i)
            SLOT_GPIO: slot_rdata = gpio_rdata_i;
            SLOT_TIM0: slot_rdata = tim0_rdata_i;
            SLOT_TIM1: slot_rdata = tim1_rdata_i;
            default:   slot_rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // response flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_acc) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // payload captured on the accepting edge
    always_ff @(posedge pbus_clock_i) begin
        if (wr_acc) begin
            bresp_o <= wr_err_i ? RESP_DECERR : RESP_OKAY;
        end
        if (rd_acc) begin
            rdata_o <= rd_err_i ? '0 : slot_rdata;
            rresp_o <= rd_err_i ? RESP_DECERR : RESP_OKAY;
        end
    end

    a_b_hold: assert property (@(posedge pbus_clock_i) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));
    a_r_hold: assert property (@(posedge pbus_clock_i) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule : pbus_resp_mux

//--- peripheral_bus.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module peripheral_bus (
    input  logic                          pbus_clock_i,
    input  logic                          rst_n_i,
    input  logic [`PBUS_ADDR_WIDTH-1:0]   awaddr_i,     // axi-lite slave port
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [`PBUS_DATA_WIDTH-1:0]   wdata_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    output logic [1:0]                    bresp_o,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    input  logic [`PBUS_ADDR_WIDTH-1:0]   araddr_i,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    output logic [`PBUS_DATA_WIDTH-1:0]   rdata_o,
    output logic [1:0]                    rresp_o,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    input  logic [`PBUS_NUM_GPIO_IN-1:0]  gpio_in_i,
    output logic [`PBUS_NUM_GPIO_OUT-1:0] gpio_out_o,
    output logic [`PBUS_NUM_IRQ-1:0]      int_o
);

    import pbus_map_pkg::*;

    pbus_addr_u                  aw_addr;               // raw word from the bus
    pbus_addr_u                  ar_addr;
    pbus_slot_e                  wr_slot;
    pbus_slot_e                  rd_slot;
    pbus_reg_idx_t               wr_idx;
    pbus_reg_idx_t               rd_idx;
    logic                        wr_err;
    logic                        rd_err;
    logic                        we;
    logic [`PBUS_DATA_WIDTH-1:0] gpio_rdata;
    logic [`PBUS_DATA_WIDTH-1:0] tim0_rdata;
    logic [`PBUS_DATA_WIDTH-1:0] tim1_rdata;
    logic                        gpio_irq;
    logic                        tim0_irq;
    logic                        tim1_irq;

    assign aw_addr.raw = awaddr_i;
    assign ar_addr.raw = araddr_i;

    // interrupt vector
    assign int_o[`PBUS_IRQ_GPIO] = gpio_irq;
    assign int_o[`PBUS_IRQ_TIM0] = tim0_irq;
    assign int_o[`PBUS_IRQ_TIM1] = tim1_irq;

    pbus_addr_decode u_decode (
        .awaddr_i  ( aw_addr ),
        .araddr_i  ( ar_addr ),
        .wr_slot_o ( wr_slot ),
        .rd_slot_o ( rd_slot ),
        .wr_idx_o  ( wr_idx  ),
        .rd_idx_o  ( rd_idx  ),
        .wr_err_o  ( wr_err  ),
        .rd_err_o  ( rd_err  )
    );

    pbus_gpio u_gpio (
        .*,
        .we_i     ( we && (wr_slot == SLOT_GPIO) ),    // write only the selected slot
        .wr_idx_i ( wr_idx     ),
        .rd_idx_i ( rd_idx     ),
        .rdata_o  ( gpio_rdata ),
        .irq_o    ( gpio_irq   )
    );

    pbus_timer u_tim0 (
        .*,
        .we_i     ( we && (wr_slot == SLOT_TIM0) ),
        .wr_idx_i ( wr_idx     ),
        .rd_idx_i ( rd_idx     ),
        .rdata_o  ( tim0_rdata ),
        .irq_o    ( tim0_irq   )
    );

    pbus_timer u_tim1 (
        .*,
        .we_i     ( we && (wr_slot == SLOT_TIM1) ),
        .wr_idx_i ( wr_idx     ),
        .rd_idx_i ( rd_idx     ),
        .rdata_o  ( tim1_rdata ),
        .irq_o    ( tim1_irq   )
    );

    // handshakes and bus-side ports by name
    pbus_resp_mux u_resp (
        .*,
        .wr_err_i     ( wr_err     ),
        .rd_err_i     ( rd_err     ),
        .rd_slot_i    ( rd_slot    ),
        .gpio_rdata_i ( gpio_rdata ),
        .tim0_rdata_i ( tim0_rdata ),
        .tim1_rdata_i ( tim1_rdata ),
        .we_o         ( we         )
    );

endmodule : peripheral_bus

//--- tb_peripheral_bus.sv
`timescale 1ns/100ps

`include "pbus_config.svh"

module tb_peripheral_bus;

    import pbus_map_pkg::*;
    import pbus_reg_pkg::*;

    localparam int          TIMEOUT_CYCLES = 50;
    localparam logic [15:0] BAD_BASE       = 16'h3000;  // outside the bus window

    logic                          pbus_clock;
    logic                          rst_n;
    logic [`PBUS_ADDR_WIDTH-1:0]   awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`PBUS_DATA_WIDTH-1:0]   wdata;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`PBUS_ADDR_WIDTH-1:0]   araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`PBUS_DATA_WIDTH-1:0]   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    logic [`PBUS_NUM_GPIO_IN-1:0]  gpio_in;
    logic [`PBUS_NUM_GPIO_OUT-1:0] gpio_out;
    logic [`PBUS_NUM_IRQ-1:0]      int_vec;

    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          test_num;
    int          test_err_base;     // errors before the running test

    // register model, updated by the test flow
    logic [7:0]  m_gpio_out;
    logic [7:0]  m_gpio_in;
    logic        m_gpio_en;
    logic        m_gpio_pend;
    logic [31:0] m_load  [0:1];
    logic [31:0] m_count [0:1];
    logic [2:0]  m_ctrl  [0:1];     // irq_en, reload, en
    logic        m_tpend [0:1];

    // pending comparisons {resp, data}
    logic [33:0] got_q [$];
    logic [33:0] exp_q [$];
    string       tag_q [$];
    event        cmp_ev;

    peripheral_bus u_peripheral_bus (
        .pbus_clock_i ( pbus_clock ),
        .rst_n_i      ( rst_n      ),
        .awaddr_i     ( awaddr     ),
        .awvalid_i    ( awvalid    ),
        .awready_o    ( awready    ),
        .wdata_i      ( wdata      ),
        .wvalid_i     ( wvalid     ),
        .wready_o     ( wready     ),
        .bresp_o      ( bresp      ),
        .bvalid_o     ( bvalid     ),
        .bready_i     ( bready     ),
        .araddr_i     ( araddr     ),
        .arvalid_i    ( arvalid    ),
        .arready_o    ( arready    ),
        .rdata_o      ( rdata      ),
        .rresp_o      ( rresp      ),
        .rvalid_o     ( rvalid     ),
        .rready_i     ( rready     ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .int_o        ( int_vec    )
    );

    initial begin
        pbus_clock = 1'b0;
        forever #10 pbus_clock = ~pbus_clock;          // 20 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;                   // xorshift32
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [15:0] base, input logic [3:0] slot,
                                             input logic [3:0] idx);
        return {base, slot, 6'b0, idx, 2'b00};
    endfunction

    function automatic logic addr_mapped(input logic [31:0] addr);
        return (addr[31:16] == `PBUS_BASE) && (addr[15:12] <= 4'd2);
    endfunction

    // expected {resp, rdata} for a read of addr
    function automatic logic [33:0] expected_read(input logic [31:0] addr);
        logic [3:0]  slot;
        logic [3:0]  idx;
        logic [31:0] data;
        int          t;
        slot = addr[15:12];
        idx  = addr[5:2];
        data = '0;
        if (!addr_mapped(addr)) begin
            return {RESP_DECERR, 32'h0};                // decerr reads zero
        end
        if (slot == 4'd0) begin
            case (idx)
                4'd0:    data[7:0] = m_gpio_out;
                4'd1:    data[7:0] = m_gpio_in;
                4'd2:    data[0]   = m_gpio_en;
                4'd3:    data[0]   = m_gpio_pend;
                default: data      = '0;
            endcase
        end else begin
            t = slot - 1;                               // timer 0 or 1
            case (idx)
                4'd0:    data      = m_load[t];
                4'd1:    data      = m_count[t];
                4'd2:    data[2:0] = m_ctrl[t];
                4'd3:    data[0]   = m_tpend[t];
                default: data      = '0;
            endcase
        end
        return {RESP_OKAY, data};
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
        logic [3:0] slot;
        logic [3:0] idx;
        int         t;
        slot = addr[15:12];
        idx  = addr[5:2];
        if (!addr_mapped(addr)) begin
            return;                                     // decerr writes nothing
        end
        if (slot == 4'd0) begin
            case (idx)
                4'd0: m_gpio_out = data[7:0];
                4'd2: m_gpio_en  = data[0];
                4'd3: m_gpio_pend = m_gpio_pend && !data[0];
                default: ;
            endcase
        end else begin
            t = slot - 1;
            case (idx)
                4'd0: begin
                    m_load[t]  = data;
                    m_count[t] = data;
                end
                4'd2: m_ctrl[t]  = data[2:0];
                4'd3: m_tpend[t] = m_tpend[t] && !data[0];
                default: ;
            endcase
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic queue_compare(input string tag, input logic [33:0] got,
                                 input logic [33:0] exp);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(tag);
        -> cmp_ev;
    endtask

    // response checker
    always @(cmp_ev) begin : compare_proc
        logic [33:0] got;
        logic [33:0] exp;
        string       tag;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            tag = tag_q.pop_front();
            checks++;
            assert (got === exp) else begin
                errors++;
                $display("FAILED at %0t: %s got resp %0d data %h, expected resp %0d data %h",
                         $time, tag, got[33:32], got[31:0], exp[33:32], exp[31:0]);
            end
        end
    end

    task automatic timeout_abort(input string what);
        $display("timeout waiting for %s after %0d cycles", what, TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("test %0d %-26s %s", test_num, name,
                 (errors == test_err_base) ? "passed" : "failed");
        test_err_base = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus tasks, entered and left 2 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input int hold);
        int         n;
        logic [1:0] resp_seen;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(posedge pbus_clock);
            #2;
            n++;
            if (n >= TIMEOUT_CYCLES) timeout_abort("awready_o and wready_o");
        end
        @(posedge pbus_clock);                          // accepting edge
        model_write(addr, data);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(posedge pbus_clock);
            #2;
            n++;
            if (n >= TIMEOUT_CYCLES) timeout_abort("bvalid_o");
        end
        resp_seen = bresp;
        queue_compare($sformatf("bresp for %h", addr), {resp_seen, 32'h0},
                      {addr_mapped(addr) ? RESP_OKAY : RESP_DECERR, 32'h0});
        repeat (hold) begin                             // back-pressure on b
            @(posedge pbus_clock);
            #2;
            check_value("bvalid_o held", bvalid, 1'b1);
            check_value("bresp_o held", bresp, resp_seen);
            check_value("awready_o while held", awready, 1'b0);
            check_value("wready_o while held", wready, 1'b0);
        end
        bready = 1'b1;
        @(posedge pbus_clock);
        #2;
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input int hold);
        int          n;
        logic [33:0] seen;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(posedge pbus_clock);
            #2;
            n++;
            if (n >= TIMEOUT_CYCLES) timeout_abort("arready_o");
        end
        @(posedge pbus_clock);
        #2;
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(posedge pbus_clock);
            #2;
            n++;
            if (n >= TIMEOUT_CYCLES) timeout_abort("rvalid_o");
        end
        seen = {rresp, rdata};
        queue_compare($sformatf("read of %h", addr), seen, expected_read(addr));
        repeat (hold) begin
            @(posedge pbus_clock);
            #2;
            check_value("rvalid_o held", rvalid, 1'b1);
            check_value("rdata_o held", rdata, seen[31:0]);
            check_value("rresp_o held", rresp, seen[33:32]);
            check_value("arready_o while held", arready, 1'b0);
        end
        rready = 1'b1;
        @(posedge pbus_clock);
        #2;
        rready = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test flow
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] val;
        logic [31:0] tim_base;
        int          n;
        int          hold;
        int          irq;
        rng_state     = 32'hd76c_1d62;
        checks        = 0;
        errors        = 0;
        test_num      = 0;
        test_err_base = 0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        gpio_in = '0;
        m_gpio_out  = '0;
        m_gpio_in   = '0;
        m_gpio_en   = 1'b0;
        m_gpio_pend = 1'b0;
        for (int t = 0; t < 2; t++) begin
            m_load[t]  = '0;
            m_count[t] = '0;
            m_ctrl[t]  = '0;
            m_tpend[t] = 1'b0;
        end
        repeat (2) @(posedge pbus_clock);
        #2;
        rst_n = 1'b1;

        // reset values
        check_value("bvalid_o", bvalid, 1'b0);
        check_value("rvalid_o", rvalid, 1'b0);
        check_value("int_o", int_vec, '0);
        check_value("gpio_out_o", gpio_out, '0);
        check_value("awready_o", awready, 1'b1);
        check_value("wready_o", wready, 1'b1);
        check_value("arready_o", arready, 1'b1);
        finish_test("reset state");

        for (int i = 0; i < 10; i++) begin
            val = next_random();
            write_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_OUT), val, 0);
            check_value("gpio_out_o", gpio_out, m_gpio_out);
            read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_OUT), 0);
        end
        finish_test("gpio output");

        write_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_IRQ_EN), 32'h1, 0);
        val = next_random();
        if (val[7:0] == 8'h00) val[7:0] = 8'h5a;        // must differ from the idle pins
        gpio_in     = val[7:0];
        m_gpio_in   = val[7:0];
        m_gpio_pend = 1'b1;
        n = 0;
        while (!int_vec[`PBUS_IRQ_GPIO]) begin
            @(posedge pbus_clock);
            #2;
            n++;
            if (n >= TIMEOUT_CYCLES) timeout_abort("the gpio interrupt");
        end
        read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_IN), 0);
        read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_IRQ_PEND), 0);
        write_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_IRQ_PEND), 32'h1, 0);
        check_value("gpio irq after clear", int_vec[`PBUS_IRQ_GPIO], m_gpio_pend && m_gpio_en);
        read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_IRQ_PEND), 0);
        finish_test("gpio input interrupt");

        for (int t = 0; t < 2; t++) begin
            tim_base = reg_addr(`PBUS_BASE, (t == 0) ? SLOT_TIM0 : SLOT_TIM1, 4'd0);
            irq      = (t == 0) ? `PBUS_IRQ_TIM0 : `PBUS_IRQ_TIM1;
            val      = (next_random() % 16) + 2;        // short one-shot run
            write_word(tim_base | (TIM_LOAD << 2), val, 0);
            write_word(tim_base | (TIM_CTRL << 2), 32'h5, 0);     // en and irq_en
            n = 0;
            while (!int_vec[irq]) begin
                @(posedge pbus_clock);
                #2;
                n++;
                if (n >= TIMEOUT_CYCLES) timeout_abort("a timer interrupt");
            end
            m_count[t] = '0;                            // expired and stopped
            m_ctrl[t]  = m_ctrl[t] & 3'b110;
            m_tpend[t] = 1'b1;
            read_word(tim_base | (TIM_STATUS << 2), 0);
            read_word(tim_base | (TIM_COUNT << 2), 0);
            read_word(tim_base | (TIM_CTRL << 2), 0);
            write_word(tim_base | (TIM_STATUS << 2), 32'h1, 0);
            check_value("timer irq after clear", int_vec[irq], 1'b0);
        end
        finish_test("timer one-shot");

        write_word(reg_addr(BAD_BASE, SLOT_GPIO, GPIO_OUT), next_random(), 0);
        read_word(reg_addr(BAD_BASE, SLOT_GPIO, GPIO_OUT), 0);
        write_word(reg_addr(`PBUS_BASE, 4'd3, 4'd0), next_random(), 0);
        read_word(reg_addr(`PBUS_BASE, 4'd3, 4'd0), 0);
        read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_OUT), 0);
        check_value("gpio_out_o after decerr", gpio_out, m_gpio_out);
        finish_test("decode error");

        for (int i = 0; i < 4; i++) begin
            hold = (next_random() % 8) + 1;
            write_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_OUT), next_random(), hold);
            hold = (next_random() % 8) + 1;
            read_word(reg_addr(`PBUS_BASE, SLOT_GPIO, GPIO_OUT), hold);
        end
        finish_test("response back-pressure");

        @(posedge pbus_clock);
        #2;
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_peripheral_bus

//--- filelist.f
+incdir+.
pbus_map_pkg.sv
pbus_reg_pkg.sv
pbus_addr_decode.sv
pbus_gpio.sv
pbus_timer.sv
pbus_resp_mux.sv
peripheral_bus.sv
tb_peripheral_bus.sv
